// ==== build.f ====
+incdir+.
conv_pad_pkg.sv
pad_mask_if.sv
col_sequencer.sv
user_skew.sv
pad_filter.sv
mask_apply.sv
conv_pad_top.sv
tb_conv_pad.sv

// ==== Makefile ====
# Verilator run of the padding mask testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_pad -f build.f -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== pad_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Reference model of the horizontal "same" padding rule. Included in the
// testbench module; gives the expected mask bits of one beat on one
// datapath from its column, the image width and the half kernel width.
////////////////////////////////////////////////////////////////////////////
`ifndef PAD_MODEL_SVH
`define PAD_MODEL_SVH

// The centre tap past the left border and the padded last column pass the sum
function automatic bit full_mask_bit(input int i, input int c, input int cols, input int k2,
                                     input bit one, input bit cfg);
    bit centre;
    bit last;
    centre = (i == 2 * k2) && (c >= k2);
    last   = (c == cols - 1) && (i >= k2) && (i <= 2 * k2);
    return centre || last || one || cfg;
endfunction

function automatic bit partial_mask_bit(input int i, input int c, input int cols, input int k2);
    if (i == 0) begin
        return 1'b1;                                          // Datapath 0 has no partial mask
    end
    if (i > 2 * k2) begin
        return 1'b0;                                          // Beyond the kernel
    end
    return !((i <= k2) && (c >= cols - 1 - k2 + i));          // Closing triangle
endfunction

function automatic bit left_col_flag(input int c);
    return c == 0;
endfunction

function automatic bit right_col_flag(input int c, input int cols);
    return c == cols - 1;
endfunction

`endif

// ==== tb_conv_pad.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the padding mask top level. Sends configs and beats on
// the falling edge, predicts each datapath's enable from the skew timing
// and checks masks, column flags and out_valid timing with assertions.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_conv_pad import conv_pad_pkg::*; ();

    typedef struct packed {
        logic                     valid;
        logic                     cfg;                        // Config beat
        logic                     one;                        // 1x1 flag
        logic [bits_kernel_w-2:0] k2;                         // Kernel width over two
        logic [bits_cols-1:0]     cols;
        logic [bits_cols-1:0]     col;
        logic [psum_width-1:0]    sum;
    } beat_t;

    logic                     aclk;
    logic                     arst_n;
    logic                     cfg_valid;
    logic [bits_kernel_w-1:0] cfg_kernel_w_1;
    logic [bits_cols-1:0]     cfg_cols;
    logic [bits_chan-1:0]     cfg_channels;
    logic                     cfg_is_1x1;
    logic                     beat_valid;
    logic [psum_width-1:0]    psum_in     [kernel_w_max-1:0];
    logic [psum_width-1:0]    full_out    [kernel_w_max-1:0];
    logic [psum_width-1:0]    partial_out [kernel_w_max-1:0];
    logic [kernel_w_max-1:0]  out_valid;
    logic [kernel_w_max-1:0]  is_left_col;
    logic [kernel_w_max-1:0]  is_right_col;

    beat_t       hist [0:15];                                 // Strobes by the cycle they went in
    beat_t       sb_q [kernel_w_max-1:0][$];                  // Beats waiting for out_valid
    logic [31:0] rng;
    int          cyc;
    int          outstanding;                                 // Datapath results still due
    bit          running;                                     // A config has been sent
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          cycle_limit;
    int          run_cycles = 0;

    `include "pad_model.svh"

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        run_cycles++;
        if (run_cycles >= cycle_limit) begin
            $display("error: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    conv_pad_top i_dut (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .cfg_valid      (cfg_valid),
        .cfg_kernel_w_1 (cfg_kernel_w_1),
        .cfg_cols       (cfg_cols),
        .cfg_channels   (cfg_channels),
        .cfg_is_1x1     (cfg_is_1x1),
        .beat_valid     (beat_valid),
        .psum_in        (psum_in),
        .full_out       (full_out),
        .partial_out    (partial_out),
        .out_valid      (out_valid),
        .is_left_col    (is_left_col),
        .is_right_col   (is_right_col)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        test_checks++;
        assert (got === exp) else begin
            test_errors++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        test_checks++;
        test_errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // Result of a beat leaves datapath i three cycles plus i after its strobe
    task automatic check_outputs();
        beat_t due;
        beat_t ent;
        logic [psum_width-1:0] exp_sum;
        for (int i = 0; i < kernel_w_max; i++) begin
            due = hist[(cyc - 3 - i) & 15];
            check_value(out_valid[i], due.valid, $sformatf("out_valid[%0d]", i));
            if (out_valid[i] && sb_q[i].size() == 0) begin
                report_failure($sformatf("datapath %0d gave a result with no beat due", i));
            end else if (out_valid[i]) begin
                ent = sb_q[i].pop_front();
                outstanding--;
                exp_sum = full_mask_bit(i, ent.col, ent.cols, ent.k2, ent.one, ent.cfg) ?
                          ent.sum : '0;
                check_value(full_out[i], exp_sum,
                            $sformatf("full_out[%0d] col %0d k2 %0d", i, ent.col, ent.k2));
                if (!ent.cfg) begin                           // Partial rule covers data beats
                    exp_sum = partial_mask_bit(i, ent.col, ent.cols, ent.k2) ? ent.sum : '0;
                    check_value(partial_out[i], exp_sum,
                                $sformatf("partial_out[%0d] col %0d k2 %0d", i, ent.col, ent.k2));
                end
            end
        end
    endtask

    // New sums every cycle; the one in the predicted enable cycle is recorded
    task automatic feed_sums();
        beat_t due;
        for (int i = 0; i < kernel_w_max; i++) begin
            rng        = xorshift32(rng);
            psum_in[i] = rng[psum_width-1:0];
            due        = hist[(cyc - 2 - i) & 15];
            if (due.valid) begin
                due.sum = rng[psum_width-1:0];
                sb_q[i].push_back(due);
                if (!due.cfg) begin
                    check_value(is_left_col[i], left_col_flag(due.col),
                                $sformatf("is_left_col[%0d] col %0d", i, due.col));
                    check_value(is_right_col[i], right_col_flag(due.col, due.cols),
                                $sformatf("is_right_col[%0d] col %0d", i, due.col));
                end
            end
        end
    endtask

    task automatic tick(input bit do_cfg, input bit do_beat, input beat_t info, input int chans);
        beat_t slot;
        @(negedge aclk);
        check_outputs();
        feed_sums();
        cfg_valid  = do_cfg;
        beat_valid = do_beat;
        if (do_cfg) begin
            cfg_kernel_w_1 = bits_kernel_w'(2 * info.k2);
            cfg_cols       = info.cols;
            cfg_channels   = bits_chan'(chans);
            cfg_is_1x1     = info.one;
            running        = 1'b1;
        end
        slot       = info;
        slot.valid = do_cfg || (do_beat && running);          // Beats before config are dropped
        hist[cyc & 15] = slot.valid ? slot : '0;
        if (slot.valid) begin
            outstanding += kernel_w_max;
        end
        cyc++;
    endtask

    task automatic send_config(input int k2, input int cols, input int chans, input bit one);
        beat_t info;
        info      = '0;
        info.cfg  = 1'b1;
        info.one  = one;
        info.k2   = k2;
        info.cols = cols;
        tick(1'b1, 1'b0, info, chans);
    endtask

    task automatic send_image(input int k2, input int cols, input int chans, input bit one);
        beat_t info;
        info      = '0;
        info.one  = one;
        info.k2   = k2;
        info.cols = cols;
        for (int c = 0; c < cols; c++) begin
            for (int ch = 0; ch < chans; ch++) begin
                info.col = c;
                tick(1'b0, 1'b1, info, chans);
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (outstanding > 0 && waited < 3 * kernel_w_max) begin
            tick(1'b0, 1'b0, '0, 0);
            waited++;
        end
        if (outstanding > 0) begin
            report_failure($sformatf("%0d datapath results never came out", outstanding));
        end
    endtask

    task automatic apply_reset();
        @(negedge aclk);
        arst_n     = 1'b0;
        cfg_valid  = 1'b0;
        beat_valid = 1'b0;
        repeat (10) @(negedge aclk);
        arst_n = 1'b1;
        for (int s = 0; s < 16; s++) begin
            hist[s] = '0;
        end
        for (int i = 0; i < kernel_w_max; i++) begin
            sb_q[i].delete();
        end
        running     = 1'b0;
        outstanding = 0;
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d passed, %0d failed", name, test_checks - test_errors,
                 test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks   = 0;
        test_errors   = 0;
    endtask

    initial begin
        aclk           = 1'b0;
        arst_n         = 1'b0;
        cfg_valid      = 1'b0;
        cfg_kernel_w_1 = '0;
        cfg_cols       = '0;
        cfg_channels   = '0;
        cfg_is_1x1     = 1'b0;
        beat_valid     = 1'b0;
        for (int i = 0; i < kernel_w_max; i++) begin
            psum_in[i] = '0;
        end
        rng          = 32'd19898;
        cyc          = 16;                                    // Keeps history lookups positive
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        // Strobes of the idle, kernel 3, kernels 7 and 5, 1x1 and back to back tests
        cycle_limit = 6 + (1 + 8 * 2) + (2 + 2 * 10 * 2) + (1 + 6 * 2) + (1 + 2 * 6) + 200;
        apply_reset();

        repeat (6) tick(1'b0, 1'b1, '0, 0);
        repeat (kernel_w_max + 3) tick(1'b0, 1'b0, '0, 0);    // Long enough to see a stray result
        drain();
        finish_test("beats before config");

        apply_reset();
        send_config(1, 8, 2, 1'b0);
        send_image(1, 8, 2, 1'b0);
        drain();
        finish_test("kernel 3");

        apply_reset();
        send_config(3, 10, 2, 1'b0);
        send_image(3, 10, 2, 1'b0);
        send_config(2, 10, 2, 1'b0);                          // Shrinks the kernel right away
        send_image(2, 10, 2, 1'b0);
        drain();
        finish_test("kernels 7 and 5");

        apply_reset();
        send_config(0, 6, 2, 1'b1);
        send_image(0, 6, 2, 1'b1);
        drain();
        finish_test("1x1");

        apply_reset();
        send_config(2, 6, 1, 1'b0);
        send_image(2, 6, 1, 1'b0);
        send_image(2, 6, 1, 1'b0);                            // Second image with no gap
        drain();
        finish_test("back to back images");

        $display("all tests: %0d passed, %0d failed", total_checks - total_errors,
                 total_errors);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== conv_pad_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Top of the padding mask subsystem. Sequencer, skew line, pad filter and
// mask stage in a row; a strobe reaches out_valid[i] after 3+i cycles.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module conv_pad_top import conv_pad_pkg::*; (
    input  logic                     aclk,
    input  logic                     arst_n,
    input  logic                     cfg_valid,
    input  logic [bits_kernel_w-1:0] cfg_kernel_w_1,
    input  logic [bits_cols-1:0]     cfg_cols,
    input  logic [bits_chan-1:0]     cfg_channels,
    input  logic                     cfg_is_1x1,
    input  logic                     beat_valid,
    input  logic [psum_width-1:0]    psum_in     [kernel_w_max-1:0],
    output logic [psum_width-1:0]    full_out    [kernel_w_max-1:0],
    output logic [psum_width-1:0]    partial_out [kernel_w_max-1:0],
    output logic [kernel_w_max-1:0]  out_valid,
    output logic [kernel_w_max-1:0]  is_left_col,
    output logic [kernel_w_max-1:0]  is_right_col
);

    logic [tuser_width-1:0]  seq_user;
    logic                    seq_valid;
    logic [tuser_width-1:0]  dp_user [kernel_w_max-1:0];     // One word per datapath
    logic [kernel_w_max-1:0] dp_en;

    pad_mask_if masks ();

    col_sequencer i_seq (
        .aclk           (aclk),
        .arst_n         (arst_n),
        .cfg_valid      (cfg_valid),
        .cfg_kernel_w_1 (cfg_kernel_w_1),
        .cfg_cols       (cfg_cols),
        .cfg_channels   (cfg_channels),
        .cfg_is_1x1     (cfg_is_1x1),
        .beat_valid     (beat_valid),
        .user_out       (seq_user),
        .user_valid     (seq_valid)
    );

    user_skew i_skew (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .user_in_0 (seq_user),
        .valid_in  (seq_valid),
        .user_out  (dp_user),
        .aclken    (dp_en)
    );

    pad_filter i_filter (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .aclken  (dp_en),
        .user_in (dp_user),
        .masks   (masks.src)
    );

    mask_apply i_apply (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .aclken      (dp_en),
        .psum_in     (psum_in),
        .masks       (masks.dst),
        .full_out    (full_out),
        .partial_out (partial_out),
        .out_valid   (out_valid)
    );

    // Column flags are valid alongside each datapath's enable
    assign is_left_col  = masks.is_left_col;
    assign is_right_col = masks.is_right_col;

endmodule

// ==== mask_apply.sv ====
////////////////////////////////////////////////////////////////////////////
// Registers the partial sums of every datapath on its own enable and
// forces the entries rejected by the padding masks to zero.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mask_apply import conv_pad_pkg::*; (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic [kernel_w_max-1:0] aclken,
    input  logic [psum_width-1:0]   psum_in     [kernel_w_max-1:0],
    pad_mask_if.dst                 masks,
    output logic [psum_width-1:0]   full_out    [kernel_w_max-1:0],
    output logic [psum_width-1:0]   partial_out [kernel_w_max-1:0],
    output logic [kernel_w_max-1:0] out_valid
);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= aclken;                              // One cycle behind the enable
        end
    end

    for (genvar i = 0; i < kernel_w_max; i++) begin : g_dp
        logic pass_partial;

        if (i == 0) begin : g_first
            assign pass_partial = 1'b1;                       // Datapath 0 has no partial mask
        end else begin : g_rest
            assign pass_partial = masks.mask_partial[i];
        end

        always_ff @(posedge aclk) begin
            if (aclken[i]) begin
                full_out[i]    <= masks.mask_full[i] ? psum_in[i] : '0;
                partial_out[i] <= pass_partial ? psum_in[i] : '0;
            end
        end
    end

endmodule

// ==== pad_filter.sv ====
////////////////////////////////////////////////////////////////////////////
// Tracks the first and last columns of the image per datapath in small
// shift registers and looks up the full and partial masks for "same"
// padding. Lookup terms exist for every odd kernel, so the kernel may
// change from one beat to the next on different datapaths.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pad_filter import conv_pad_pkg::*; (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic [kernel_w_max-1:0] aclken,
    input  logic [tuser_width-1:0]  user_in [kernel_w_max-1:0],
    pad_mask_if.src                 masks
);

    for (genvar i = 0; i < kernel_w_max; i++) begin : g_dp
        logic [bits_kernel_w-2:0] kw2_sel;                    // Kernel width divided by two
        logic                     reg_en;
        logic [kw2_max:1]         col_end;                    // Bit j high in column cols-1-k2+j
        logic [kw2_max:1]         col_start;                  // Bit j high in column j-1
        logic [kw2_max:0]         end_ext;
        logic [kw2_max:0]         lut_full;

        // (kw-1)/2 is just the upper bits of the kernel field
        assign kw2_sel = user_in[i][i_kernel_w_1+bits_kernel_w-1 : i_kernel_w_1+1];
        assign reg_en  = aclken[i] && user_in[i][i_is_acc_last] && !user_in[i][i_is_config];
        assign end_ext = {col_end, user_in[i][i_is_cols_1_k2]}; // Bit 0 serves the 1x1 kernel

        always_ff @(posedge aclk or negedge arst_n) begin
            if (!arst_n) begin
                col_end   <= '0;
                col_start <= kw2_max'(1);                     // First image starts at column 0
            end else if (reg_en) begin
                col_end   <= end_ext[kw2_max-1:0];
                // Last column of this image becomes the first of the next
                col_start <= {col_start[kw2_max-1:1], end_ext[kw2_sel]};
            end
        end

        for (genvar k = 0; k <= kw2_max; k++) begin : g_full
            logic start_cols;
            logic mid_ok;
            logic last_ok;

            if (k == 0) begin : g_k0
                assign start_cols = 1'b0;
            end else begin : g_kn
                assign start_cols = |col_start[k:1];          // First k columns are blocked
            end
            assign mid_ok      = (i == 2*k) && !start_cols;   // Only the centre tap is whole
            assign last_ok     = end_ext[k] && (i >= k) && (i <= 2*k); // Padded last column
            assign lut_full[k] = mid_ok || last_ok || user_in[i][i_is_1x1]
                                 || user_in[i][i_is_config];
        end

        assign masks.mask_full[i]    = lut_full[kw2_sel];
        assign masks.is_left_col[i]  = col_start[1];
        assign masks.is_right_col[i] = end_ext[kw2_sel];

        if (i > 0) begin : g_part
            logic [kw2_max:0] lut_stop;

            for (genvar k = 0; k <= kw2_max; k++) begin : g_k
                if (i <= k) begin : g_tri
                    assign lut_stop[k] = |col_end[k:i];       // Rows of the closing triangle
                end else begin : g_open
                    assign lut_stop[k] = (i > 2*k);           // Datapath beyond the kernel
                end
            end

            assign masks.mask_partial[i] = !lut_stop[kw2_sel];
        end
    end

endmodule

// ==== user_skew.sv ====
////////////////////////////////////////////////////////////////////////////
// Systolic skew line. Datapath i receives the user word and its clock
// enable i cycles after datapath 0, which itself lags the input by one.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module user_skew import conv_pad_pkg::*; (
    input  logic                    aclk,
    input  logic                    arst_n,
    input  logic [tuser_width-1:0]  user_in_0,
    input  logic                    valid_in,
    output logic [tuser_width-1:0]  user_out [kernel_w_max-1:0],
    output logic [kernel_w_max-1:0] aclken
);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            aclken <= '0;
        end else begin
            aclken <= {aclken[kernel_w_max-2:0], valid_in};   // Strobe walks one datapath per cycle
        end
    end

    // Words shift every cycle so each stays aligned with its strobe
    always_ff @(posedge aclk) begin
        user_out[0] <= user_in_0;
        for (int i = 1; i < kernel_w_max; i++) begin
            user_out[i] <= user_out[i-1];
        end
    end

endmodule

// ==== col_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// Counts channels and columns of the incoming image and builds the user
// word for each beat. A config strobe loads the geometry and sends one
// config beat; each later beat strobe sends one data beat, a cycle later.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module col_sequencer import conv_pad_pkg::*; (
    input  logic                     aclk,
    input  logic                     arst_n,
    input  logic                     cfg_valid,
    input  logic [bits_kernel_w-1:0] cfg_kernel_w_1,
    input  logic [bits_cols-1:0]     cfg_cols,
    input  logic [bits_chan-1:0]     cfg_channels,
    input  logic                     cfg_is_1x1,
    input  logic                     beat_valid,
    output logic [tuser_width-1:0]   user_out,
    output logic                     user_valid
);

    seq_state_e               state;
    logic [bits_chan-1:0]     chan;
    logic [bits_cols-1:0]     col;
    logic [bits_kernel_w-1:0] kernel_w_1;                     // Loaded geometry
    logic [bits_cols-1:0]     cols_1;
    logic [bits_chan-1:0]     chan_1;
    logic                     is_1x1;
    logic                     last_chan;
    logic                     last_col;
    logic                     col_k2;
    logic                     beat_run;

    assign beat_run  = (state == s_run) && beat_valid && !cfg_valid; // Config wins a collision
    assign last_chan = (chan == chan_1);
    assign last_col  = (col == cols_1);
    // Column cols-1-k2 with k2 taken from the loaded kernel
    assign col_k2    = (col == cols_1 - bits_cols'(kernel_w_1[bits_kernel_w-1:1]));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= s_wait_cfg;
            chan       <= '0;
            col        <= '0;
            user_valid <= 1'b0;
        end else begin
            user_valid <= cfg_valid || beat_run;
            if (cfg_valid) begin
                state <= s_run;
                chan  <= '0;
                col   <= '0;
            end else if (beat_run) begin
                if (last_chan) begin
                    chan <= '0;
                    col  <= last_col ? '0 : col + 1'b1;       // Wrap into the next image
                end else begin
                    chan <= chan + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (cfg_valid) begin
            kernel_w_1 <= cfg_kernel_w_1;
            cols_1     <= cfg_cols - 1'b1;
            chan_1     <= cfg_channels - 1'b1;
            is_1x1     <= cfg_is_1x1;
            user_out   <= '0;
            user_out[i_kernel_w_1 +: bits_kernel_w] <= cfg_kernel_w_1;
            user_out[i_is_1x1]    <= cfg_is_1x1;
            user_out[i_is_config] <= 1'b1;                    // Config beat carries no data
        end else if (beat_run) begin
            user_out[i_kernel_w_1 +: bits_kernel_w] <= kernel_w_1;
            user_out[i_is_1x1]       <= is_1x1;
            user_out[i_is_config]    <= 1'b0;
            user_out[i_is_acc_last]  <= last_chan;
            user_out[i_is_cols_1_k2] <= col_k2;
        end
    end

endmodule

// ==== pad_mask_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Carries the two padding masks and the column flags from the pad filter
// to the mask stage. Purely combinational, no handshake.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface pad_mask_if import conv_pad_pkg::*; ();

    logic [kernel_w_max-1:0] mask_full;                       // Pass the full sum
    logic [kernel_w_max-1:1] mask_partial;                    // Pass the partial sum
    logic [kernel_w_max-1:0] is_left_col;
    logic [kernel_w_max-1:0] is_right_col;

    modport src (output mask_full, mask_partial, is_left_col, is_right_col);
    modport dst (input  mask_full, mask_partial, is_left_col, is_right_col);

endinterface

// ==== conv_pad_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared sizes, user-word bit positions and the sequencer state type for
// the horizontal padding mask subsystem. Imported by every block that
// needs a width or a field position.
////////////////////////////////////////////////////////////////////////////
package conv_pad_pkg;

    localparam int kernel_w_max  = 7;                         // Parallel column datapaths
    localparam int kw2_max       = kernel_w_max / 2;          // Largest half kernel width
    localparam int bits_kernel_w = $clog2(kernel_w_max);      // Holds kernel width minus one
    localparam int bits_cols     = 8;                         // Column counter width
    localparam int bits_chan     = 8;                         // Channel counter width
    localparam int psum_width    = 16;                        // One partial sum

    // User word has one flag per bit and the kernel field on top
    localparam int i_is_1x1       = 0;
    localparam int i_is_cols_1_k2 = 1;                        // Column cols-1-k2 of the image
    localparam int i_is_config    = 2;
    localparam int i_is_acc_last  = 3;                        // Last channel of a column
    localparam int i_kernel_w_1   = 4;                        // Lowest bit of the kernel field
    localparam int tuser_width    = i_kernel_w_1 + bits_kernel_w;

    typedef enum logic {
        s_wait_cfg,                                           // No geometry loaded yet
        s_run                                                 // Counting beats of an image
    } seq_state_e;

endpackage
